//--- bmc_ctrl_if.sv
interface bmc_ctrl_if;

    // synchronized controller strobes, all active low
    logic bss;      // shift start
    logic bsen;     // shift enable, field rotates while low
    logic repen;    // replicator enable
    logic booten;   // bootloop access
    logic swapen;   // swap gate enable

    // synchronizer side
    modport sync_src
    (
        output bss, bsen, repen, booten, swapen
    );

    // decoder side
    modport fsm_sink
    (
        input bss, bsen, repen, booten, swapen
    );

endinterface

//--- bubble_config.svh
`ifndef BUBBLE_CONFIG_SVH
`define BUBBLE_CONFIG_SVH

// divider, 48 MHz master down to 4 MHz
`define BUB_DIV_PHASES     12     // MCLK per controller clock
`define BUB_CLKOUT_RISE    5      // clkout goes high here
`define BUB_CLKOUT_FALL    11     // clkout goes low, last phase

// field timer marks, counted in MCLK (480 per bubble cycle)
`define BUB_FIELD_START    88     // first input enable after start
`define BUB_FIELD_MINUS_X  208    // timer may park here
`define BUB_FIELD_MINUS_Y  326    // output enable mark
`define BUB_FIELD_PLUS_Y   568    // end of one rotation
`define BUB_FIELD_LOOP     89     // 568 -> 89 keeps the 480 period

// loop geometry
`define BUB_POS_LAST       2052   // 2053 positions per minor loop
`define BUB_POS_INIT       1951   // position after power up

// serial output numbering
`define BUB_PROP_CYCLES    98     // cycles from replicator to detector
`define BUB_PAGE_LAST      583    // 584 bits per page
`define BUB_BOOT_LAST      4105   // both bootloops interleaved

// output cycle value while nothing is on the detector
`define BUB_NO_DATA        8191

`endif

//--- bubble_ctrl_pkg.sv
package bubble_ctrl_pkg;

    // access type, decoded from the controller strobes
    //   bit 2: magnetic field rotating
    //   bit 1: data transfer active
    //   bit 0: page instead of bootloop, swap instead of idle
    typedef enum logic [2:0]
    {
        RST  = 3'b000,  // nothing going on
        STBY = 3'b001,  // bss seen, waiting for bsen
        BOOT = 3'b110,  // bootloop read
        USER = 3'b111,  // page read, replicator fired
        IDLE = 3'b100,  // field turning, seeking a page
        SWAP = 3'b101   // page write through swap gate
    } access_t;

    // master clock phase inside one 4 MHz period
    // runs 0..11, sampling happens on 3, 7 and 11
    typedef logic [3:0] div_phase_t;

endpackage

//--- bubble_geom_pkg.sv
package bubble_geom_pkg;

    // absolute loop position, 0..2052
    typedef logic [11:0] abs_pos_t;

    // serial output cycle number
    // bootloop 0..4105, page 0..583, 8191 when empty
    typedef logic [12:0] bout_cycle_t;

    // MCLK count inside the field rotation, 0..568
    typedef logic [9:0] field_count_t;

    // bit counter inside one page, all ones when empty
    typedef logic [9:0] page_cycle_t;

endpackage

//--- bubble_timing_gen.f
+incdir+.
bubble_ctrl_pkg.sv
bubble_geom_pkg.sv
bmc_ctrl_if.sv
tg_clock_divider.sv
tg_input_sync.sv
tg_access_fsm.sv
tg_field_timer.sv
tg_bout_counters.sv
bubble_timing_gen.sv
bubble_timing_gen_tb.sv

//--- bubble_timing_gen.sv
module bubble_timing_gen
    import bubble_ctrl_pkg::*;
    import bubble_geom_pkg::*;
(
    input  logic        MCLK,           // 48 MHz
    input  logic        rst_n,
    input  logic        en_n,
    input  logic        bss_n,
    input  logic        bsen_n,
    input  logic        repen_n,
    input  logic        booten_n,
    input  logic        swapen_n,
    output logic        clkout,         // 4 MHz controller clock
    output access_t     acc_type,
    output bout_cycle_t bout_cycle_num,
    output logic        bin_clk_en_n,
    output logic        bout_clk_en_n,
    output abs_pos_t    abs_pos
);

    logic sample_stb;
    logic field_idle;
    logic plus_y_stb;

    bmc_ctrl_if u_ctrl_if ();  // synchronized strobes

    tg_clock_divider u_clock_divider (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .clkout     (clkout),
        .sample_stb (sample_stb)
    );

    tg_input_sync u_input_sync (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .sample_stb (sample_stb),
        .en_n       (en_n),
        .bss_n      (bss_n),
        .bsen_n     (bsen_n),
        .repen_n    (repen_n),
        .booten_n   (booten_n),
        .swapen_n   (swapen_n),
        .ctrl       (u_ctrl_if.sync_src)
    );

    tg_access_fsm u_access_fsm (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .ctrl     (u_ctrl_if.fsm_sink),
        .acc_type (acc_type)
    );

    tg_field_timer u_field_timer (
        .MCLK          (MCLK),
        .rst_n         (rst_n),
        .acc_type      (acc_type),
        .field_idle    (field_idle),
        .plus_y_stb    (plus_y_stb),
        .bin_clk_en_n  (bin_clk_en_n),
        .bout_clk_en_n (bout_clk_en_n)
    );

    tg_bout_counters u_bout_counters (
        .MCLK           (MCLK),
        .rst_n          (rst_n),
        .acc_type       (acc_type),
        .field_idle     (field_idle),
        .plus_y_stb     (plus_y_stb),
        .abs_pos        (abs_pos),
        .bout_cycle_num (bout_cycle_num)
    );

endmodule

//--- bubble_timing_gen_tb.sv
`include "bubble_config.svh"

module bubble_timing_gen_tb
    import bubble_ctrl_pkg::*;
    import bubble_geom_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int FIELD_CYCLE  = `BUB_FIELD_PLUS_Y - `BUB_FIELD_LOOP + 1;  // 480 MCLK
    localparam int BIN_TO_BOUT  = `BUB_FIELD_MINUS_Y - `BUB_FIELD_START;    // 238 MCLK
    localparam int FIELD_BUDGET = 820;  // field cycles over all tests

    logic        MCLK;
    logic        rst_n;
    logic        en_n;
    logic [4:0]  strb_n;  // {bss, bsen, repen, booten, swapen}, active low
    logic        clkout;
    access_t     acc_type;
    bout_cycle_t bout_cycle_num;
    logic        bin_clk_en_n;
    logic        bout_clk_en_n;
    abs_pos_t    abs_pos;

    string test_name;
    int    errors;
    int    test_errors_at_start;
    int    tests_run;
    int    tests_failed;
    bit    field_check_on;  // field keeps turning from here on

    // reference model state, all updated on the falling edge
    int    plus_y_cnt;
    int    model_pos;
    int    model_boot;
    int    user_events;   // plus_y events spent in USER
    int    boot_events;
    int    since_fall;
    int    bout_low_run;
    int    exp_bout;
    bit    have_prev;
    logic  bin_prev;

    bubble_timing_gen u_bubble_timing_gen (
        .MCLK           (MCLK),
        .rst_n          (rst_n),
        .en_n           (en_n),
        .bss_n          (strb_n[4]),
        .bsen_n         (strb_n[3]),
        .repen_n        (strb_n[2]),
        .booten_n       (strb_n[1]),
        .swapen_n       (strb_n[0]),
        .clkout         (clkout),
        .acc_type       (acc_type),
        .bout_cycle_num (bout_cycle_num),
        .bin_clk_en_n   (bin_clk_en_n),
        .bout_clk_en_n  (bout_clk_en_n),
        .abs_pos        (abs_pos)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #(CLK_PERIOD / 2) MCLK = ~MCLK;
    end

    task automatic expect_value(input string what, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            errors++;
            $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        int n;
        n = errors - test_errors_at_start;
        if (n != 0)
            tests_failed++;
        $display("test %s: %s, %0d error(s)", test_name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    task automatic apply_reset();
        @(negedge MCLK);
        rst_n = 1'b0;
        repeat (4) @(negedge MCLK);
        rst_n = 1'b1;  // regs still hold reset values until next rising edge
    endtask

    // drive one input change, then wait for the decoded access type
    task automatic step_inputs(input logic en_v, input logic [4:0] strb_v, input access_t exp);
        int waited;
        bit hold;
        @(negedge MCLK);
        en_n   = en_v;
        strb_n = strb_v;
        hold   = (acc_type == exp);  // no change expected, watch the whole window
        waited = 0;
        while ((hold || acc_type != exp) && waited < 8)  // sync + sample + FSM worst case
        begin
            @(negedge MCLK);
            waited++;
            if (hold && acc_type != exp)
                break;  // state left while it should hold
        end
        assert (acc_type == exp)
        else
        begin
            errors++;
            $display("[ERROR] %s: acc_type expected %s actual %s",
                     test_name, exp.name(), acc_type.name());
        end
        repeat ($urandom_range(11, 4)) @(negedge MCLK);  // random gap to the next strobe
    endtask

    function automatic int event_count(input int sel);
        case (sel)
            1:       return user_events;
            2:       return boot_events;
            default: return plus_y_cnt;
        endcase
    endfunction

    // 0 = any plus_y, 1 = in USER, 2 = in BOOT
    task automatic wait_events(input int sel, input int target);
        int waited;
        waited = 0;
        while (event_count(sel) < target && waited < (target + 2) * FIELD_CYCLE)
        begin
            @(negedge MCLK);
            waited++;
        end
        assert (event_count(sel) >= target)
        else
        begin
            errors++;
            $display("test %s: field cycles stopped after %0d of %0d",
                     test_name, event_count(sel), target);
        end
    endtask

    // plus_y model, a bin pulse 480 MCLK after the previous one
    always @(negedge MCLK)
    begin
        if (!rst_n)
        begin
            plus_y_cnt   = 0;
            model_pos    = `BUB_POS_INIT;
            model_boot   = `BUB_POS_INIT;
            user_events  = 0;
            boot_events  = 0;
            since_fall   = 0;
            bout_low_run = 0;
            have_prev    = 1'b0;
            bin_prev     = 1'b1;
        end
        else
        begin
            since_fall++;
            bout_low_run = bout_clk_en_n ? 0 : bout_low_run + 1;
            if (bout_low_run > 1)
                have_prev = 1'b0;  // timer parked, next bin pulse is the start mark
            if (acc_type != USER)
                user_events = 0;
            if (acc_type != BOOT)
                boot_events = 0;
            if (bin_prev && !bin_clk_en_n)
            begin
                if (field_check_on && have_prev)
                    expect_value("bin_clk_en_n spacing", FIELD_CYCLE, since_fall);
                if (have_prev && since_fall == FIELD_CYCLE)
                begin
                    plus_y_cnt++;
                    model_pos  = (model_pos == `BUB_POS_LAST) ? 0 : model_pos + 1;
                    model_boot = (model_boot == `BUB_BOOT_LAST) ? 0 : model_boot + 1;
                    if (acc_type == USER)
                        user_events++;
                    if (acc_type == BOOT)
                        boot_events++;
                    if (acc_type == USER)
                        exp_bout = (user_events <= `BUB_PROP_CYCLES) ? `BUB_NO_DATA :
                                   (user_events - `BUB_PROP_CYCLES - 1) % (`BUB_PAGE_LAST + 1);
                    else if (acc_type == BOOT)
                        exp_bout = (boot_events <= `BUB_PROP_CYCLES) ? `BUB_NO_DATA : model_boot;
                    else
                        exp_bout = `BUB_NO_DATA;  // nothing on the detector
                    expect_value("abs_pos", model_pos, abs_pos);
                    expect_value("bout_cycle_num", exp_bout, bout_cycle_num);
                end
                have_prev  = 1'b1;
                since_fall = 0;
            end
            bin_prev = bin_clk_en_n;
        end
    end

    a_clkout_low: assert property (@(posedge MCLK) disable iff (!rst_n)
        $fell(clkout) |-> ##6 $rose(clkout))
        else
        begin
            errors++;
            $display("test %s: clkout low time is not 6 MCLK", test_name);
        end

    a_clkout_high: assert property (@(posedge MCLK) disable iff (!rst_n)
        $rose(clkout) |-> ##6 $fell(clkout))
        else
        begin
            errors++;
            $display("test %s: clkout high time is not 6 MCLK", test_name);
        end

    a_bout_after_bin: assert property (@(posedge MCLK) disable iff (!rst_n || !field_check_on)
        $fell(bin_clk_en_n) |-> ##BIN_TO_BOUT $fell(bout_clk_en_n))
        else
        begin
            errors++;
            $display("test %s: bout_clk_en_n did not fall 238 MCLK after bin_clk_en_n", test_name);
        end

    // run limit from the field cycle budget plus some margin
    initial
    begin
        #(FIELD_BUDGET * FIELD_CYCLE * CLK_PERIOD * 12 / 10);
        $display("watchdog expired, tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        void'($urandom(69672));
        rst_n          = 1'b0;
        en_n           = 1'b0;
        strb_n         = 5'b11111;
        field_check_on = 1'b0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_name      = "init";

        start_test("reset_and_clkout");
        apply_reset();
        expect_value("clkout", 1, clkout);
        expect_value("acc_type", RST, acc_type);
        expect_value("bin_clk_en_n", 1, bin_clk_en_n);
        expect_value("bout_clk_en_n", 0, bout_clk_en_n);
        expect_value("abs_pos", `BUB_POS_INIT, abs_pos);
        expect_value("bout_cycle_num", `BUB_NO_DATA, bout_cycle_num);
        repeat (4 * `BUB_DIV_PHASES) @(negedge MCLK);  // a few clkout periods
        finish_test();

        start_test("access_sequence");
        step_inputs(1'b0, 5'b01111, STBY);  // bss pulse
        step_inputs(1'b0, 5'b11111, STBY);
        step_inputs(1'b0, 5'b10111, IDLE);  // bsen low, page side
        step_inputs(1'b0, 5'b10011, USER);  // repen pulse
        step_inputs(1'b0, 5'b10111, USER);
        step_inputs(1'b0, 5'b11111, RST);
        step_inputs(1'b0, 5'b01111, STBY);
        step_inputs(1'b0, 5'b11111, STBY);
        step_inputs(1'b0, 5'b10111, IDLE);
        step_inputs(1'b0, 5'b10110, SWAP);  // swapen pulse
        step_inputs(1'b0, 5'b10111, SWAP);
        step_inputs(1'b0, 5'b11111, RST);
        step_inputs(1'b0, 5'b11101, RST);   // bootloop selected
        step_inputs(1'b0, 5'b01101, STBY);
        step_inputs(1'b0, 5'b11101, STBY);
        step_inputs(1'b0, 5'b10101, BOOT);
        step_inputs(1'b1, 5'b10101, RST);   // disabled, strobes read idle
        step_inputs(1'b1, 5'b11111, RST);
        step_inputs(1'b0, 5'b11111, RST);
        finish_test();

        start_test("field_spacing");
        apply_reset();
        field_check_on = 1'b1;
        step_inputs(1'b0, 5'b01111, STBY);
        step_inputs(1'b0, 5'b11111, STBY);
        step_inputs(1'b0, 5'b10111, IDLE);
        wait_events(0, 5);
        finish_test();

        start_test("page_numbering");
        step_inputs(1'b0, 5'b10011, USER);
        step_inputs(1'b0, 5'b10111, USER);
        wait_events(1, `BUB_PROP_CYCLES + `BUB_PAGE_LAST + 3);  // past one page wrap
        finish_test();

        start_test("bootloop_numbering");
        step_inputs(1'b0, 5'b11111, RST);
        apply_reset();
        step_inputs(1'b0, 5'b11101, RST);
        step_inputs(1'b0, 5'b01101, STBY);
        step_inputs(1'b0, 5'b11101, STBY);
        step_inputs(1'b0, 5'b10101, BOOT);
        wait_events(2, `BUB_PROP_CYCLES + 6);
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- tg_access_fsm.sv
module tg_access_fsm
    import bubble_ctrl_pkg::*;
(
    input  logic    MCLK,
    input  logic    rst_n,
    bmc_ctrl_if.fsm_sink ctrl,
    output access_t acc_type
);

    access_t state;
    access_t state_nxt;
    logic [4:0] pattern;

    // same order as the controller's decode table
    assign pattern = {ctrl.bss, ctrl.booten, ctrl.bsen, ctrl.repen, ctrl.swapen};

    always_comb
    begin
        state_nxt = state;  // unknown patterns keep the state
        case (pattern)
            // everything released, bootloop or page side
            5'b10111, 5'b11111:
            begin
                if (state != STBY)
                    state_nxt = RST;
            end
            // shift start pulse
            5'b00111, 5'b01111:
            begin
                if (state == RST)
                    state_nxt = STBY;
            end
            // bsen low with bootloop selected
            5'b10011:
            begin
                if (state == STBY || state == BOOT || state == RST)
                    state_nxt = BOOT;
            end
            // bsen low, page side, seeking
            5'b11011:
            begin
                if (state == STBY || state == RST)
                    state_nxt = IDLE;
            end
            5'b11001:
            begin
                if (state == IDLE)
                    state_nxt = USER;  // replicator pulse starts a page read
            end
            5'b11010:
            begin
                if (state == IDLE)
                    state_nxt = SWAP;  // swap pulse starts a page write
            end
            default:
            begin
                state_nxt = state;
            end
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            state <= RST;
        else
            state <= state_nxt;
    end

    assign acc_type = state;

    a_state_legal: assert property (@(posedge MCLK) disable iff (!rst_n)
        state inside {RST, STBY, BOOT, USER, IDLE, SWAP})
        else $error("access state illegal: %b", state);

endmodule

//--- tg_bout_counters.sv
`include "bubble_config.svh"

module tg_bout_counters
    import bubble_ctrl_pkg::*;
    import bubble_geom_pkg::*;
(
    input  logic        MCLK,
    input  logic        rst_n,
    input  access_t     acc_type,
    input  logic        field_idle,
    input  logic        plus_y_stb,
    output abs_pos_t    abs_pos,
    output bout_cycle_t bout_cycle_num
);

    logic [6:0]  prop_cnt;   // all ones = delay not started
    page_cycle_t page_cnt;   // all ones = no page bit yet
    bout_cycle_t boot_cnt;   // free running, both bootloops
    bout_cycle_t boot_nxt;
    page_cycle_t page_nxt;
    logic        prop_done;

    assign boot_nxt = (boot_cnt < `BUB_BOOT_LAST) ? boot_cnt + 1'b1 : '0;
    assign page_nxt = (page_cnt < `BUB_PAGE_LAST) ? page_cnt + 1'b1 : '0;  // also empty -> 0

    // replicated bubble has reached the detector
    assign prop_done = (prop_cnt != '1) && (prop_cnt >= `BUB_PROP_CYCLES - 1);

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            abs_pos        <= abs_pos_t'(`BUB_POS_INIT);
            boot_cnt       <= bout_cycle_t'(`BUB_POS_INIT);
            bout_cycle_num <= bout_cycle_t'(`BUB_NO_DATA);
            prop_cnt       <= '1;
            page_cnt       <= '1;
        end
        else
        begin
            // loop position moves on every rotation, whatever the access
            if (plus_y_stb)
            begin
                abs_pos  <= (abs_pos < `BUB_POS_LAST) ? abs_pos + 1'b1 : '0;
                boot_cnt <= boot_nxt;
            end

            if (field_idle && acc_type == RST)
            begin
                bout_cycle_num <= bout_cycle_t'(`BUB_NO_DATA);
                prop_cnt       <= '1;
                page_cnt       <= '1;
            end
            else if (plus_y_stb)
            begin
                if (!acc_type[1])  // idle or swap, detector line empty
                begin
                    bout_cycle_num <= bout_cycle_t'(`BUB_NO_DATA);
                    prop_cnt       <= '1;
                    page_cnt       <= '1;
                end
                else if (!prop_done)
                begin
                    bout_cycle_num <= bout_cycle_t'(`BUB_NO_DATA);
                    prop_cnt       <= prop_cnt + 1'b1;  // empty wraps to 0
                    page_cnt       <= '1;
                end
                else if (!acc_type[0])
                    bout_cycle_num <= boot_nxt;  // bootloop bit number
                else
                begin
                    page_cnt       <= page_nxt;
                    bout_cycle_num <= {3'b000, page_nxt};
                end
            end
        end
    end

    a_bout_range: assert property (@(posedge MCLK) disable iff (!rst_n)
        (bout_cycle_num <= `BUB_BOOT_LAST) || (bout_cycle_num == `BUB_NO_DATA))
        else $error("bout_cycle_num out of range: %0d", bout_cycle_num);

endmodule

//--- tg_clock_divider.sv
`include "bubble_config.svh"

module tg_clock_divider
    import bubble_ctrl_pkg::*;
(
    input  logic MCLK,
    input  logic rst_n,
    output logic clkout,     // 4 MHz to the controller
    output logic sample_stb  // one MCLK every third of a 4 MHz period
);

    div_phase_t phase;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            phase  <= '0;
            clkout <= 1'b1;  // controller clock idles high
        end
        else
        begin
            if (phase == div_phase_t'(`BUB_DIV_PHASES - 1))
                phase <= '0;
            else
                phase <= phase + 1'b1;

            if (phase == div_phase_t'(`BUB_CLKOUT_RISE))
                clkout <= 1'b1;
            else if (phase == div_phase_t'(`BUB_CLKOUT_FALL))
                clkout <= 1'b0;  // controller launches strobes on this edge
        end
    end

    // phases 3, 7, 11 all end in 2'b11
    assign sample_stb = (phase[1:0] == 2'b11);

    a_phase_range: assert property (@(posedge MCLK) disable iff (!rst_n)
        phase < `BUB_DIV_PHASES)
        else $error("divider phase out of range: %0d", phase);

endmodule

//--- tg_field_timer.sv
`include "bubble_config.svh"

module tg_field_timer
    import bubble_ctrl_pkg::*;
    import bubble_geom_pkg::*;
(
    input  logic    MCLK,
    input  logic    rst_n,
    input  access_t acc_type,
    output logic    field_idle,     // timer parked at 0
    output logic    plus_y_stb,     // field at +Y, once per bubble cycle
    output logic    bin_clk_en_n,   // sample write data
    output logic    bout_clk_en_n   // launch read data
);

    field_count_t field_cnt;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            field_cnt <= '0;
        else if (field_cnt == '0)
        begin
            if (acc_type[2])
                field_cnt <= field_cnt + 1'b1;  // field starts rotating
        end
        else if (field_cnt == field_count_t'(`BUB_FIELD_MINUS_X))
        begin
            if (acc_type[2])
                field_cnt <= field_cnt + 1'b1;
            else
                field_cnt <= '0;  // rotation stops at -X
        end
        else if (field_cnt == field_count_t'(`BUB_FIELD_PLUS_Y))
            field_cnt <= field_count_t'(`BUB_FIELD_LOOP);  // next cycle, 480 later
        else
            field_cnt <= field_cnt + 1'b1;
    end

    assign field_idle = (field_cnt == '0);
    assign plus_y_stb = (field_cnt == field_count_t'(`BUB_FIELD_PLUS_Y));

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            bin_clk_en_n  <= 1'b1;
            bout_clk_en_n <= 1'b0;  // low while idle
        end
        else
        begin
            bin_clk_en_n <= !(field_cnt == field_count_t'(`BUB_FIELD_START) || plus_y_stb);
            // bubble reaches the detector at -Y
            bout_clk_en_n <= !(field_idle ||
                               field_cnt == field_count_t'(`BUB_FIELD_MINUS_Y));
        end
    end

    a_plus_y_single: assert property (@(posedge MCLK) disable iff (!rst_n)
        plus_y_stb |=> !plus_y_stb)
        else $error("plus_y_stb held for more than one MCLK");

endmodule

//--- tg_input_sync.sv
module tg_input_sync
(
    input  logic MCLK,
    input  logic rst_n,
    input  logic sample_stb,
    input  logic en_n,       // whole emulator disabled while high
    input  logic bss_n,
    input  logic bsen_n,
    input  logic repen_n,
    input  logic booten_n,
    input  logic swapen_n,
    bmc_ctrl_if.sync_src ctrl
);

    // bit order {swapen, bss, bsen, repen, booten}
    logic [4:0] gated;
    logic [4:0] sync_s1;
    logic [4:0] sync_s2;
    logic [4:0] sync_s3;

    assign gated[4] = en_n | swapen_n;
    assign gated[3] = en_n | bss_n;
    assign gated[2] = en_n | bsen_n;
    assign gated[1] = en_n | repen_n | ~booten_n;  // no replication during bootloop read
    assign gated[0] = ~en_n & booten_n;            // disabled reads as bootloop select

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            sync_s1 <= 5'b11110;  // inactive pattern, booten low
            sync_s2 <= 5'b11110;
            sync_s3 <= 5'b11110;
            {ctrl.swapen, ctrl.bss, ctrl.bsen, ctrl.repen, ctrl.booten} <= 5'b11110;
        end
        else
        begin
            sync_s1 <= gated;
            sync_s2 <= sync_s1;
            sync_s3 <= sync_s2;
            if (sample_stb)  // take a settled value only on divider phases
                {ctrl.swapen, ctrl.bss, ctrl.bsen, ctrl.repen, ctrl.booten} <= sync_s3;
        end
    end

endmodule
